//--- hdl/rob_defs.svh
// reorder buffer sizing
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// number of reorder buffer slots, a power of two and at least 4
`define ROB_SIZE 16

// number of physical registers behind the rename stage
`define PRF_SIZE 64

// width of a tag that names one slot
`define ROB_TAG_W $clog2(`ROB_SIZE)

// width of a physical register number
`define PRN_W $clog2(`PRF_SIZE)

`endif

//--- hdl/rob_pkg.sv
// reorder buffer types
`include "rob_defs.svh"

package rob_pkg;

	// one renamed instruction as it leaves the rename stage
	typedef struct packed {
		logic [63:0]          pc;         // fetch address of the instruction
		logic [4:0]           arn_dest;   // architected destination register
		logic [`PRN_W-1:0]    prn_dest;   // physical register given by rename
		logic                 is_branch;  // instruction can redirect the front end
		logic                 halt;       // stops retirement once committed
		logic                 illegal;    // decode found no valid opcode
		logic [31:0]          inst;       // raw instruction word, kept for debug
	} dispatch_t;

	// result reported by an execution unit
	typedef struct packed {
		logic [`ROB_TAG_W-1:0] tag;        // slot the finished instruction sits in
		logic                  mispredict; // branch outcome differs from prediction
		logic [63:0]           target_pc;  // correct next pc after the branch
	} complete_t;

	// contents of one slot as seen by the commit stage
	typedef struct packed {
		logic                 inuse;      // slot holds a live instruction
		logic                 executed;   // result has come back from execution
		logic [63:0]          pc;
		logic [4:0]           arn_dest;
		logic [`PRN_W-1:0]    prn_dest;
		logic                 is_branch;
		logic                 halt;
		logic                 illegal;
		logic [31:0]          inst;
		logic                 mispredict; // captured from the completion
		logic [63:0]          target_pc;  // captured from the completion
	} entry_state_t;

	// one retired instruction, consumed by the retirement rename table
	typedef struct packed {
		logic                 valid;      // high for one cycle per retirement
		logic [63:0]          pc;
		logic [4:0]           arn_dest;
		logic [`PRN_W-1:0]    prn_dest;
		logic                 is_branch;
		logic                 mispredict;
		logic [63:0]          target_pc;
		logic                 halt;
		logic                 illegal;
		logic [31:0]          inst;
	} commit_t;

endpackage

//--- hdl/rob_entry.sv
// reorder buffer slot
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_entry import rob_pkg::*;
#(
	parameter int ENTRY_ID = 0                  // tag this slot answers to
)
(
	input  logic         clock,
	input  logic         reset,
	input  logic         load,                 // dispatch writes this slot at the next edge
	input  logic         entry_sel,            // 1 takes the second dispatch slot, 0 the first
	input  dispatch_t    dispatch1,
	input  dispatch_t    dispatch2,
	input  logic         complete_valid,       // one cycle pulse from execution
	input  complete_t    complete,
	input  logic         retire,               // slot is the head and leaves this cycle
	input  logic         flush,                // mispredict wipes the whole buffer
	output entry_state_t state
);

	localparam int TAG_W = `ROB_TAG_W;

	dispatch_t    src;                         // payload picked from the two dispatch slots
	logic         hit;                         // completion is aimed at this live slot
	entry_state_t next_state;

	assign src = entry_sel ? dispatch2 : dispatch1;   // second slot only when tag2 lands here

	// a completion for a free slot is stale and must not touch anything
	assign hit = complete_valid && state.inuse && (complete.tag == TAG_W'(ENTRY_ID));

	always_comb
	begin
		next_state = state;                    // hold by default
		if (flush)
		begin
			next_state.inuse      = 1'b0;      // everything in flight is on the wrong path
			next_state.executed   = 1'b0;
			next_state.mispredict = 1'b0;
		end
		else if (load)
		begin
			// a reload wins over a retire in the same edge, the new instruction simply
			// replaces the one that leaves
			next_state.inuse      = 1'b1;
			next_state.executed   = 1'b0;      // fresh instruction has not run yet
			next_state.mispredict = 1'b0;      // outcome unknown until completion
			next_state.pc         = src.pc;
			next_state.arn_dest   = src.arn_dest;
			next_state.prn_dest   = src.prn_dest;
			next_state.is_branch  = src.is_branch;
			next_state.halt       = src.halt;
			next_state.illegal    = src.illegal;
			next_state.inst       = src.inst;
		end
		else if (retire)
		begin
			next_state.inuse    = 1'b0;        // slot returns to the free pool
			next_state.executed = 1'b0;
		end
		else if (hit)
		begin
			next_state.executed   = 1'b1;
			next_state.mispredict = complete.mispredict;  // branch outcome from execution
			next_state.target_pc  = complete.target_pc;   // redirect address if mispredicted
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state.inuse      <= 1'b0;          // all slots start free
			state.executed   <= 1'b0;
			state.mispredict <= 1'b0;
		end
		else
		begin
			state <= next_state;
		end
	end

endmodule

//--- hdl/rob_dispatch.sv
// reorder buffer dispatch stage
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_dispatch
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dispatch1_valid,  // older of the two instructions
	input  logic                  dispatch2_valid,  // only meaningful with dispatch1_valid
	input  logic                  commit_pulse,     // one slot retired this cycle
	input  logic                  flush,            // empty the buffer at the next edge
	output logic                  dispatch_ready,   // room for two more instructions
	output logic [`ROB_TAG_W-1:0] tag1,
	output logic [`ROB_TAG_W-1:0] tag2,
	output logic [`ROB_SIZE-1:0]  entry_load,       // one-hot per accepted instruction
	output logic [`ROB_SIZE-1:0]  entry_sel         // marks the slot that takes instruction 2
);

	localparam int TAG_W = `ROB_TAG_W;
	localparam int CNT_W = `ROB_TAG_W + 1;    // occupancy must reach ROB_SIZE itself

	logic [TAG_W-1:0] tail;                    // next free slot in program order
	logic [CNT_W-1:0] count;                   // slots currently in flight
	logic             accept1;
	logic             accept2;

	// keep two slots spare so a two-wide dispatch never overruns the head
	assign dispatch_ready = (count <= CNT_W'(`ROB_SIZE - 2));

	// strobes are dropped while not ready or while the buffer is being flushed
	assign accept1 = dispatch1_valid && dispatch_ready && !flush;
	assign accept2 = accept1 && dispatch2_valid;

	assign tag1 = tail;
	assign tag2 = tail + TAG_W'(1);           // wraps modulo ROB_SIZE

	always_comb
	begin
		entry_load = '0;
		entry_sel  = '0;
		for (int i = 0; i < `ROB_SIZE; i++)
		begin
			if (accept1 && (tag1 == TAG_W'(i)))
				entry_load[i] = 1'b1;         // instruction 1 goes to the tail
			if (accept2 && (tag2 == TAG_W'(i)))
			begin
				entry_load[i] = 1'b1;         // instruction 2 goes right behind it
				entry_sel[i]  = 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			tail  <= '0;                       // refill starts over at slot 0
			count <= '0;
		end
		else
		begin
			tail  <= tail + TAG_W'(accept1) + TAG_W'(accept2);
			count <= count + CNT_W'(accept1) + CNT_W'(accept2) - CNT_W'(commit_pulse);
		end
	end

endmodule

//--- hdl/rob_commit.sv
// reorder buffer commit stage
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_commit import rob_pkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  entry_state_t         states [0:`ROB_SIZE-1],
	output logic [`ROB_SIZE-1:0] entry_commit,     // one-hot, frees the head slot
	output logic                 commit_pulse,     // tells dispatch the count drops
	output commit_t              commit,           // registered retirement record
	output logic                 flush,            // one cycle, same cycle as the record
	output logic [63:0]          flush_pc,
	output logic                 halted            // stays high until reset
);

	localparam int TAG_W = `ROB_TAG_W;

	logic [TAG_W-1:0] head;                    // oldest instruction in program order
	entry_state_t     head_state;
	logic             halt_pending;            // halt record is on the output right now
	logic             retire;
	commit_t          record;

	assign head_state = states[head];

	assign halt_pending = commit.valid && commit.halt;

	// nothing leaves behind a halt or during the flush cycle, younger slots are dead then
	assign retire = head_state.inuse && head_state.executed
		&& !halted && !halt_pending && !flush;

	assign commit_pulse = retire;

	always_comb
	begin
		entry_commit = '0;
		for (int i = 0; i < `ROB_SIZE; i++)
			if (retire && (head == TAG_W'(i)))
				entry_commit[i] = 1'b1;
	end

	always_comb
	begin
		record.valid      = retire;
		record.pc         = head_state.pc;
		record.arn_dest   = head_state.arn_dest;
		record.prn_dest   = head_state.prn_dest;
		record.is_branch  = head_state.is_branch;
		record.mispredict = head_state.mispredict;
		record.target_pc  = head_state.target_pc;
		record.halt       = head_state.halt;
		record.illegal    = head_state.illegal;
		record.inst       = head_state.inst;
	end

	always_ff @(posedge clock)
	begin
		if (reset || flush)
			head <= '0;                        // dispatch restarts at slot 0 as well
		else if (retire)
			head <= head + TAG_W'(1);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			commit.valid <= 1'b0;
			flush        <= 1'b0;
			halted       <= 1'b0;
		end
		else
		begin
			commit   <= record;                // valid follows retire by one cycle
			flush    <= retire && head_state.is_branch && head_state.mispredict;
			flush_pc <= head_state.target_pc;  // only looked at while flush is high
			if (halt_pending)
				halted <= 1'b1;               // rises right after the halt record
		end
	end

endmodule

//--- hdl/rob_top.sv
// reorder buffer top level
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_top import rob_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dispatch1_valid,
	input  logic                  dispatch2_valid,
	input  dispatch_t             dispatch1,        // older instruction of the pair
	input  dispatch_t             dispatch2,
	output logic                  dispatch_ready,
	output logic [`ROB_TAG_W-1:0] tag1,             // tag handed to dispatch1
	output logic [`ROB_TAG_W-1:0] tag2,             // tag handed to dispatch2
	input  logic                  complete_valid,
	input  complete_t             complete,
	output commit_t               commit,
	output logic                  flush,
	output logic [63:0]           flush_pc,
	output logic                  halted
);

	logic [`ROB_SIZE-1:0] entry_load;          // dispatch write strobes
	logic [`ROB_SIZE-1:0] entry_sel;           // payload select per slot
	logic [`ROB_SIZE-1:0] entry_commit;        // head slot leaving this cycle
	logic                 commit_pulse;
	entry_state_t         states [0:`ROB_SIZE-1];

	rob_dispatch u_dispatch
	(
		.clock           (clock),
		.reset           (reset),
		.dispatch1_valid (dispatch1_valid),
		.dispatch2_valid (dispatch2_valid),
		.commit_pulse    (commit_pulse),
		.flush           (flush),
		.dispatch_ready  (dispatch_ready),
		.tag1            (tag1),
		.tag2            (tag2),
		.entry_load      (entry_load),
		.entry_sel       (entry_sel)
	);

	// every slot sees both payloads and the completion bus, its strobes pick what it takes
	for (genvar i = 0; i < `ROB_SIZE; i++)
	begin : g_entry
		rob_entry
		#(
			.ENTRY_ID (i)
		)
		u_entry
		(
			.clock          (clock),
			.reset          (reset),
			.load           (entry_load[i]),
			.entry_sel      (entry_sel[i]),
			.dispatch1      (dispatch1),
			.dispatch2      (dispatch2),
			.complete_valid (complete_valid),
			.complete       (complete),
			.retire         (entry_commit[i]),
			.flush          (flush),
			.state          (states[i])
		);
	end

	rob_commit u_commit
	(
		.clock        (clock),
		.reset        (reset),
		.states       (states),
		.entry_commit (entry_commit),
		.commit_pulse (commit_pulse),
		.commit       (commit),
		.flush        (flush),
		.flush_pc     (flush_pc),
		.halted       (halted)
	);

endmodule

//--- tb/rob_sva.sv
// reorder buffer assertions
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_sva import rob_pkg::*;
(
	input logic    clock,
	input logic    reset,
	input commit_t commit,
	input logic    flush,
	input logic    halted,
	input logic    dispatch_ready
);

	// a retired halt freezes the commit port
	a_no_commit_when_halted : assert property (
		@(posedge clock) disable iff (reset)
		commit.valid |-> !halted
	) else $error("commit record while halted");

	// redirects only come from a retiring mispredicted branch
	a_flush_needs_branch : assert property (
		@(posedge clock) disable iff (reset)
		flush |-> commit.valid && commit.is_branch && commit.mispredict
	) else $error("flush without a committed mispredicted branch");

	// the buffer is empty right after reset
	a_ready_after_reset : assert property (
		@(posedge clock)
		$fell(reset) |-> dispatch_ready
	) else $error("dispatch not ready after reset");

endmodule

bind rob_top rob_sva u_sva (.*);

//--- tb/rob_tb.sv
// reorder buffer testbench
`timescale 1ns/1ps
`include "rob_defs.svh"

module rob_tb import rob_pkg::*;
();

	typedef struct {
		logic [`ROB_TAG_W-1:0] tag;          // tag the model expects the DUT to hand out
		dispatch_t             d;
		logic                  mispredict;   // filled in by the completion command
		logic [63:0]           target_pc;
	} model_t;

	logic                  clock;
	logic                  reset;
	logic                  dispatch1_valid;
	logic                  dispatch2_valid;
	dispatch_t             dispatch1;
	dispatch_t             dispatch2;
	logic                  dispatch_ready;
	logic [`ROB_TAG_W-1:0] tag1;
	logic [`ROB_TAG_W-1:0] tag2;
	logic                  complete_valid;
	complete_t             complete;
	commit_t               commit;
	logic                  flush;
	logic [63:0]           flush_pc;
	logic                  halted;

	model_t                model_q [$];      // in-flight instructions, oldest first
	logic [`ROB_TAG_W-1:0] model_tail;       // predicted tag of the next dispatch
	bit                    model_halted;     // a halt has retired
	string                 lines [$];        // stim commands without comments
	bit                    loaded;
	int                    errors;
	int                    checks;

	rob_top dut (.*);

	always #10 clock = ~clock;                 // 20 ns period

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] %0d ns %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("[ERROR] %0d ns %s", $time, what);
	endtask

	// inputs change 2 ns after the edge so they are settled before the DUT samples them
	task automatic step();
		@(posedge clock);
		#2;
	endtask

	function automatic dispatch_t make_payload(input logic [63:0] pc, input logic [63:0] arn,
		input logic [63:0] prn, input logic [63:0] flags, input logic [63:0] inst);
		dispatch_t d;
		d.pc        = pc;
		d.arn_dest  = arn[4:0];
		d.prn_dest  = prn[`PRN_W-1:0];
		d.is_branch = flags[2];                // flag digit holds branch, halt and illegal
		d.halt      = flags[1];
		d.illegal   = flags[0];
		d.inst      = inst[31:0];
		return d;
	endfunction

	task automatic dispatch_group(input int n, input dispatch_t d1, input dispatch_t d2);
		bit                    accept;
		model_t                ent;
		logic [`ROB_TAG_W-1:0] next_tag;
		accept   = model_q.size() <= `ROB_SIZE - 2;   // two slots are always kept spare
		next_tag = model_tail + 1'b1;
		compare("dispatch_ready", accept, dispatch_ready);
		compare("tag1", model_tail, tag1);
		compare("tag2", next_tag, tag2);
		dispatch1       = d1;
		dispatch2       = d2;
		dispatch1_valid = 1'b1;
		dispatch2_valid = (n == 2);
		if (accept)
		begin
			ent = '{tag: model_tail, d: d1, mispredict: 1'b0, target_pc: '0};
			model_q.push_back(ent);
			model_tail = model_tail + 1'b1;
			if (n == 2)
			begin
				ent = '{tag: model_tail, d: d2, mispredict: 1'b0, target_pc: '0};
				model_q.push_back(ent);
				model_tail = model_tail + 1'b1;
			end
		end
		step();
		dispatch1_valid = 1'b0;
		dispatch2_valid = 1'b0;
	endtask

	task automatic complete_one(input logic [63:0] tag, input logic [63:0] mis,
		input logic [63:0] target);
		complete_valid       = 1'b1;
		complete.tag         = tag[`ROB_TAG_W-1:0];
		complete.mispredict  = mis[0];
		complete.target_pc   = target;
		foreach (model_q[i])
			if (model_q[i].tag == tag[`ROB_TAG_W-1:0])
			begin
				model_q[i].mispredict = mis[0];    // a tag nobody holds leaves the model alone
				model_q[i].target_pc  = target;
			end
		step();
		complete_valid = 1'b0;
	endtask

	task automatic wait_inflight(input int n);
		int waited;
		waited = 0;
		while (model_q.size() != n && waited < 50)
		begin
			step();
			waited++;
		end
		if (model_q.size() != n)
			report_error($sformatf("timed out waiting for %0d instructions in flight, model holds %0d",
				n, model_q.size()));
	endtask

	// every record is held against the oldest model entry
	always @(negedge clock)
	begin : monitor
		model_t exp_rec;
		bit     redirect;
		if (!reset)
		begin
			if (commit.valid)
			begin
				if (model_halted)
					report_error("a commit appeared after a committed halt");
				else if (model_q.size() == 0)
					report_error("a commit appeared with no instruction in flight");
				else
				begin
					exp_rec  = model_q.pop_front();
					redirect = exp_rec.d.is_branch && exp_rec.mispredict;
					compare("commit.pc", exp_rec.d.pc, commit.pc);
					compare("commit.arn_dest", exp_rec.d.arn_dest, commit.arn_dest);
					compare("commit.prn_dest", exp_rec.d.prn_dest, commit.prn_dest);
					compare("commit.is_branch", exp_rec.d.is_branch, commit.is_branch);
					compare("commit.mispredict", exp_rec.mispredict, commit.mispredict);
					compare("commit.target_pc", exp_rec.target_pc, commit.target_pc);
					compare("commit.halt", exp_rec.d.halt, commit.halt);
					compare("commit.illegal", exp_rec.d.illegal, commit.illegal);
					compare("commit.inst", exp_rec.d.inst, commit.inst);
					compare("flush", redirect, flush);
					if (redirect)
					begin
						compare("flush_pc", exp_rec.target_pc, flush_pc);
						model_q.delete();          // younger work is on the wrong path
						model_tail = '0;
					end
					if (exp_rec.d.halt)
						model_halted = 1'b1;
				end
			end
			else
				compare("flush", 1'b0, flush);
		end
	end

	initial
	begin : watchdog
		wait (loaded);
		repeat (lines.size() * 50) @(posedge clock);   // 50 cycles per command
		$display("[ERROR] %0d ns the run did not finish in time", $time);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin : main
		int          fd;
		int          tests;
		int          test_errors;
		int          gap;
		string       line;
		string       cmd;
		string       name;
		logic [63:0] f [0:9];
		logic [`ROB_TAG_W-1:0] pending [$];
		logic [`ROB_TAG_W-1:0] exp_tag1;
		logic [`ROB_TAG_W-1:0] exp_tag2;
		clock           = 1'b0;
		reset           = 1'b1;
		dispatch1_valid = 1'b0;
		dispatch2_valid = 1'b0;
		dispatch1       = '0;
		dispatch2       = '0;
		complete_valid  = 1'b0;
		complete        = '0;
		model_tail      = '0;
		model_halted    = 1'b0;
		errors          = 0;
		checks          = 0;
		tests           = 0;
		test_errors     = 0;
		name            = "";
		void'($urandom(52464));
		fd = $fopen("tb/rob_stim.txt", "r");
		if (fd == 0)
		begin
			$display("[ERROR] the stimulus file tb/rob_stim.txt could not be opened");
			$display("FAIL: see errors above");
			$finish;
		end
		else
		begin
			while ($fgets(line, fd) > 0)
				if (line.len() > 1 && line.getc(0) != "#")
					lines.push_back(line);
			$fclose(fd);
			loaded = 1'b1;
			repeat (4) @(posedge clock);       // reset held for four cycles
			#2;
			reset = 1'b0;
			foreach (lines[k])
			begin
				void'($sscanf(lines[k], "%s %h %h %h %h %h %h %h %h %h %h", cmd,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]));
				case (cmd)
					"B":
					begin
						void'($sscanf(lines[k], "%s %s", cmd, name));
						test_errors = errors;
					end
					"E":
					begin
						tests++;
						$display("test %s finished with %0d errors", name, errors - test_errors);
					end
					"D": dispatch_group(1, make_payload(f[0], f[1], f[2], f[3], f[4]), '0);
					"P": dispatch_group(2, make_payload(f[0], f[1], f[2], f[3], f[4]),
						make_payload(f[5], f[6], f[7], f[8], f[9]));
					"F":
						// generated payloads whose pc steps by 4 from the given base
						for (int i = 0; i < f[0]; i += 2)
							dispatch_group((f[0] - i >= 2) ? 2 : 1,
								make_payload(f[1] + 4 * i, i, i + 8, 0, 32'h13 | (i << 7)),
								make_payload(f[1] + 4 * (i + 1), i + 1, i + 9, 0,
									32'h13 | ((i + 1) << 7)));
					"C": complete_one(f[0], f[1], f[2]);
					"A":
					begin
						pending.delete();
						foreach (model_q[i])
							pending.push_back(model_q[i].tag);
						foreach (pending[i])
							complete_one(pending[i], 0, 0);
					end
					"I":
					begin
						gap = f[0] + ($urandom % 3);   // a little random slack between bursts
						repeat (gap) step();
					end
					"Q": wait_inflight(f[0]);
					"R": compare("dispatch_ready", f[0][0], dispatch_ready);
					"H": compare("halted", f[0][0], halted);
					"T":
					begin
						exp_tag1 = f[0][`ROB_TAG_W-1:0];
						exp_tag2 = exp_tag1 + 1'b1;    // wraps modulo ROB_SIZE
						compare("tag1", exp_tag1, tag1);
						compare("tag2", exp_tag2, tag2);
					end
					default: report_error($sformatf("unknown stimulus command %s", cmd));
				endcase
			end
			step();
			$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
			if (errors == 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

endmodule

//--- tb/rob_stim.txt
# one command per line, operands in hex
# B name, E | D pc arn prn flags inst | P two D groups | F count pc | C tag mis target | A | I n | Q n | R | T tag | H
B reset_state
H 0
R 1
T 0
E
B in_order_commit
P 1000 1 21 1 00a00093 1004 2 22 0 00000013
P 1008 3 23 4 fe000ee3 100c 4 24 0 00b00113
C 3 0 0
C 2 0 2000
C 1 0 0
C 0 0 0
Q 0
E
B fill_and_wrap
F f 2000
R 0
D 3000 5 30 0 00000013
C 4 0 0
Q e
R 1
T 3
A
Q 0
E
B mispredict_flush
P 4000 6 31 4 00008067 4004 7 32 0 00000013
D 4008 8 33 0 00000013
C 4 0 0
C 5 0 0
C 3 1 8000
I 3
Q 0
T 0
E
B unused_tag
D 5000 9 34 0 00000013
C 7 1 dead
I 3
Q 1
C 0 0 0
Q 0
E
B halt_stops_commit
D 6000 a 35 2 00100073
P 6004 b 36 0 00000013 6008 c 37 1 ffffffff
C 2 0 0
C 3 0 0
C 1 0 0
I 5
H 1
Q 2
E

//--- tb.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_entry.sv
hdl/rob_dispatch.sv
hdl/rob_commit.sv
hdl/rob_top.sv
tb/rob_sva.sv
tb/rob_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the reorder buffer testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f tb.f \
	-o rob_sim > build.log 2>&1 \
	&& ./obj_dir/rob_sim > sim.log 2>&1 \
	|| { echo "build or simulation aborted"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "PASS: all tests" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
